// ==== test/exec_vectors.hex ====
// mark flush | alu: valid op a_src b_src a b | shift: valid op a_src b_src a b
// expected per cycle: alu valid flags data | shift valid flags data (flags = z s c v)
1 0  1 01 0 0 7fffffffffffffff 1  1 10 0 0 1 3f  0 0 0  0 0 0
1 0  1 01 0 0 ffffffffffffffff 1  1 11 0 0 8000000000000000 7f  0 0 0  0 0 0
1 0  1 03 0 0 5 7  1 12 0 0 8000000000000000 4  1 5 8000000000000000  1 4 8000000000000000
1 0  1 04 0 0 aaaaaaaa80000000 1  1 13 0 0 ffffffff 1  1 a 0  1 0 1
1 0  1 02 0 0 5ffffffff 2  1 13 0 0 2 1f  1 6 fffffffffffffffe  1 4 f800000000000000
1 0  1 05 0 0 ff00 ff0  1 14 0 0 ff80000000 24  1 1 7fffffff  1 4 fffffffe
1 0  1 06 0 0 8000000000000000 1  1 15 0 0 80000000 1f  1 2 1  1 8 0
1 0  1 07 0 0 ff f0  1 12 0 0 7000000000000000 3c  1 0 f00  1 0 8000000
1 0  1 01 1 4 0 0  1 10 3 0 0 4  1 4 8000000000000001  1 4 ffffffff
1 0  1 03 2 3 0 0  1 11 4 1 0 0  1 0 f  1 0 7
1 0  1 07 1 3 0 0  1 12 1 4 0 0  1 4 8000000008000001  1 0 f000
1 0  1 02 2 4 0 0  1 10 2 3 0 0  1 7 8000000000000006  1 0 1ffff
1 0  1 05 2 1 0 0  1 11 3 0 0 3c  1 4 800000000800000e  1 4 ff00000000100000
1 0  1 01 0 0 1 1  1 10 0 0 1 1  1 0 2efff  1 0 3fffe
1 1  1 01 0 0 3 3  1 10 0 0 3 2  1 4 8000000000000000  1 0 8
1 0  1 06 0 0 a0 b  1 11 0 0 f00 8  0 0 0  0 0 0
1 0  1 04 0 0 3 3  1 15 0 0 f0000000 4  0 0 0  0 0 0
1 0  0 00 0 0 0 0  0 00 0 0 0 0  1 0 ab  1 0 f
1 0  0 00 0 0 0 0  0 00 0 0 0 0  1 8 0  1 4 ff000000
1 0  0 00 0 0 0 0  0 00 0 0 0 0  0 0 0  0 0 0
1 0  0 00 0 0 0 0  0 00 0 0 0 0  0 0 0  0 0 0
2 0  0 00 0 0 0 0  0 00 0 0 0 0  0 0 0  0 0 0

// ==== flist.f ====
design/exec_pkg.sv
design/operand_forward.sv
design/issue_latch.sv
design/alu_lane.sv
design/shift_lane.sv
design/exec_cluster.sv
test/tb_clock.sv
test/exec_cluster_tb.sv

// ==== Makefile ====
VERILATOR := verilator
TOP       := exec_cluster_tb
FLIST     := flist.f
VFLAGS    := --binary --timing --timescale 1ns/100ps
LINTFLAGS := --lint-only --timing --timescale 1ns/100ps
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := === FAIL ===
PASS_MSG  := === PASS ===

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "no pass message in log"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== test/exec_cluster_tb.sv ====
`timescale 1ns/100ps

module exec_cluster_tb;

  import exec_pkg::*;

  localparam int line_words   = 20;
  localparam int max_lines    = 32;
  localparam int reset_cycles = 8;
  localparam int time_limit   = (reset_cycles + max_lines + 4) * 100;

  // word offsets inside one vector line
  localparam int w_mark      = 0;
  localparam int w_flush     = 1;
  localparam int w_alu_req   = 2;
  localparam int w_shift_req = 8;
  localparam int w_alu_exp   = 14;
  localparam int w_shift_exp = 17;

  localparam logic [63:0] mark_cycle = 64'd1;
  localparam logic [63:0] mark_end   = 64'd2;

  logic         clk;
  logic         reset;
  logic         flush;
  issue_req_t   alu_issue;
  issue_req_t   shift_issue;
  lane_result_t alu_result;
  lane_result_t shift_result;

  logic [63:0] vectors [0:line_words*max_lines-1];
  int          line_no;

  tb_clock clk_gen (.clk(clk));

  exec_cluster dut0 (
    .clk(clk), .reset(reset), .flush(flush),
    .alu_issue(alu_issue), .shift_issue(shift_issue),
    .alu_result(alu_result), .shift_result(shift_result)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] expected);
    if (got !== expected) begin
      stop_with_failure($sformatf("ERROR at %0t ns: %s is %h, expected %h (vector line %0d)",
                                  $time, name, got, expected, line_no));
    end
  endtask

  function automatic issue_req_t request_from_words(input int first);
    issue_req_t req;
    req.valid = vectors[first][0];
    req.op    = op_t'(vectors[first + 1][op_width-1:0]);
    req.a_src = fwd_src_t'(vectors[first + 2][2:0]);
    req.b_src = fwd_src_t'(vectors[first + 3][2:0]);
    req.a     = vectors[first + 4];
    req.b     = vectors[first + 5];
    return req;
  endfunction

  task automatic apply_line(input int base);
    flush       <= vectors[base + w_flush][0];
    alu_issue   <= request_from_words(base + w_alu_req);
    shift_issue <= request_from_words(base + w_shift_req);
  endtask

  // data and flags only matter while valid is expected
  task automatic check_lane(input string lane, input lane_result_t got, input int first);
    check_value({lane, ".valid"}, 64'(got.valid), vectors[first]);
    if (vectors[first] == 64'd1) begin
      check_value({lane, ".flags"}, 64'(got.flags), vectors[first + 1]);
      check_value({lane, ".data"}, got.data, vectors[first + 2]);
    end
  endtask

  initial begin : watchdog
    #(time_limit);
    stop_with_failure("simulation time limit reached before the vectors ended");
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // main sequence
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin : main
    int base;
    bit done;
    reset             = 1'b1;
    flush             = 1'b0;
    // valid issues held during reset must not reach the lanes
    alu_issue         = '0;
    alu_issue.valid   = 1'b1;
    alu_issue.op      = op_add64;
    shift_issue       = '0;
    shift_issue.valid = 1'b1;
    shift_issue.op    = op_shl64;
    line_no           = 0;
    done              = 1'b0;
    $readmemh("test/exec_vectors.hex", vectors);
    for (int i = 0; i < reset_cycles; i++) begin
      @(posedge clk);
    end
    reset       <= 1'b0;
    alu_issue   <= '0;
    shift_issue <= '0;
    // drive on the rising edge, check at the falling edge
    while (!done) begin
      if (line_no >= max_lines) begin
        stop_with_failure("no end marker found in the vector file");
      end
      base = line_no * line_words;
      @(posedge clk);
      if (vectors[base + w_mark] == mark_end) begin
        done = 1'b1;
      end else if (vectors[base + w_mark] == mark_cycle) begin
        apply_line(base);
        @(negedge clk);
        check_lane("alu_result", alu_result, base + w_alu_exp);
        check_lane("shift_result", shift_result, base + w_shift_exp);
        line_no++;
      end else begin
        stop_with_failure($sformatf("vector line %0d has an unknown mark", line_no));
      end
    end
    $display("=== PASS ===");
    $finish;
  end

endmodule

// ==== test/tb_clock.sv ====
`timescale 1ns/100ps

module tb_clock (
  output logic clk
);

  // 100 ns period
  localparam int half_period = 50;

  initial begin
    clk = 1'b0;
    forever begin
      #(half_period) clk = ~clk;
    end
  end

endmodule

// ==== design/exec_cluster.sv ====
`timescale 1ns/100ps

module exec_cluster (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   flush,
  input  exec_pkg::issue_req_t   alu_issue,
  input  exec_pkg::issue_req_t   shift_issue,
  output exec_pkg::lane_result_t alu_result,
  output exec_pkg::lane_result_t shift_result
);

  import exec_pkg::*;

  data_t    alu_now;
  data_t    alu_late;
  data_t    shift_now;
  data_t    shift_late;
  data_t    alu_a;
  data_t    alu_b;
  data_t    shift_a;
  data_t    shift_b;
  lane_op_t alu_op;
  lane_op_t shift_op;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // operand forwarding
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  operand_forward alu_a_fwd (
    .src(alu_issue.a_src), .issued(alu_issue.a),
    .alu_now(alu_now), .shift_now(shift_now),
    .alu_late(alu_late), .shift_late(shift_late),
    .operand(alu_a)
  );

  operand_forward alu_b_fwd (
    .src(alu_issue.b_src), .issued(alu_issue.b),
    .alu_now(alu_now), .shift_now(shift_now),
    .alu_late(alu_late), .shift_late(shift_late),
    .operand(alu_b)
  );

  operand_forward shift_a_fwd (
    .src(shift_issue.a_src), .issued(shift_issue.a),
    .alu_now(alu_now), .shift_now(shift_now),
    .alu_late(alu_late), .shift_late(shift_late),
    .operand(shift_a)
  );

  operand_forward shift_b_fwd (
    .src(shift_issue.b_src), .issued(shift_issue.b),
    .alu_now(alu_now), .shift_now(shift_now),
    .alu_late(alu_late), .shift_late(shift_late),
    .operand(shift_b)
  );

  // issue to lane, one cycle each
  issue_latch alu_latch (
    .clk(clk), .reset(reset), .flush(flush),
    .req(alu_issue), .a(alu_a), .b(alu_b), .lane_op(alu_op)
  );

  issue_latch shift_latch (
    .clk(clk), .reset(reset), .flush(flush),
    .req(shift_issue), .a(shift_a), .b(shift_b), .lane_op(shift_op)
  );

  alu_lane alu0 (
    .clk(clk), .reset(reset), .flush(flush), .lane_op(alu_op),
    .result(alu_result), .now(alu_now), .late(alu_late)
  );

  shift_lane shift0 (
    .clk(clk), .reset(reset), .flush(flush), .lane_op(shift_op),
    .result(shift_result), .now(shift_now), .late(shift_late)
  );

endmodule

// ==== design/shift_lane.sv ====
`timescale 1ns/100ps

module shift_lane (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   flush,
  input  exec_pkg::lane_op_t     lane_op,
  output exec_pkg::lane_result_t result,
  output exec_pkg::data_t        now,
  output exec_pkg::data_t        late
);

  import exec_pkg::*;

  logic [shamt_width-1:0] amt;
  data_t                  src;
  data_t                  raw;
  data_t                  res;
  logic                   sign;
  lane_result_t           now_q;
  data_t                  late_q;

  always_comb begin
    if (lane_op.ctl.is_wide) begin
      amt = lane_op.b[shamt_width-1:0];
      src = lane_op.a;
    end else begin
      amt = {1'b0, lane_op.b[shamt_width-2:0]};
      // widen the low word so one 64-bit shifter serves both sizes
      if (lane_op.ctl.arith) begin
        src = {{half_width{lane_op.a[half_width-1]}}, lane_op.a[half_width-1:0]};
      end else begin
        src = {{half_width{1'b0}}, lane_op.a[half_width-1:0]};
      end
    end
    if (!lane_op.ctl.shift_right) begin
      raw = src << amt;
    end else if (lane_op.ctl.arith) begin
      raw = $signed(src) >>> amt;
    end else begin
      raw = src >> amt;
    end
    res  = lane_op.ctl.is_wide ? raw : {{half_width{1'b0}}, raw[half_width-1:0]};
    sign = lane_op.ctl.is_wide ? raw[data_width-1] : raw[half_width-1];
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      now_q  <= '0;
      late_q <= '0;
    end else begin
      now_q.valid <= lane_op.valid && !flush;
      if (lane_op.valid) begin
        now_q.data  <= res;
        now_q.flags <= {res == '0, sign, 2'b00};
      end
      late_q <= now_q.data;
    end
  end

  assign result = now_q;
  assign now    = now_q.data;
  assign late   = late_q;

endmodule

// ==== design/alu_lane.sv ====
`timescale 1ns/100ps

module alu_lane (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   flush,
  input  exec_pkg::lane_op_t     lane_op,
  output exec_pkg::lane_result_t result,
  output exec_pkg::data_t        now,
  output exec_pkg::data_t        late
);

  import exec_pkg::*;

  logic [data_width:0] sum64;
  logic [half_width:0] sum32;
  data_t               b_eff;
  data_t               raw;
  data_t               res;
  flags_t              flags;
  logic                sign;
  logic                carry_out;
  logic                a_top;
  logic                b_top;
  logic                is_logic;
  lane_result_t        now_q;
  data_t               late_q;

  // subtract as a + ~b + 1
  assign b_eff = lane_op.ctl.is_sub ? ~lane_op.b : lane_op.b;
  assign sum64 = {1'b0, lane_op.a} + {1'b0, b_eff} +
                 {{data_width{1'b0}}, lane_op.ctl.is_sub};
  assign sum32 = {1'b0, lane_op.a[half_width-1:0]} + {1'b0, b_eff[half_width-1:0]} +
                 {{half_width{1'b0}}, lane_op.ctl.is_sub};
  assign is_logic = lane_op.ctl.logic_sel != sel_arith;

  always_comb begin
    case (lane_op.ctl.logic_sel)
      sel_and: raw = lane_op.a & lane_op.b;
      sel_or:  raw = lane_op.a | lane_op.b;
      sel_xor: raw = lane_op.a ^ lane_op.b;
      default: raw = sum64[data_width-1:0];
    endcase
    if (lane_op.ctl.is_wide) begin
      res       = raw;
      sign      = raw[data_width-1];
      carry_out = sum64[data_width];
      a_top     = lane_op.a[data_width-1];
      b_top     = b_eff[data_width-1];
    end else begin
      // low half of sum64 equals sum32
      res       = {{half_width{1'b0}}, raw[half_width-1:0]};
      sign      = raw[half_width-1];
      carry_out = sum32[half_width];
      a_top     = lane_op.a[half_width-1];
      b_top     = b_eff[half_width-1];
    end
    // borrow is the inverted carry out
    flags = {res == '0, sign,
             !is_logic && (carry_out ^ lane_op.ctl.is_sub),
             !is_logic && (a_top == b_top) && (sign != a_top)};
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // now and late registers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    if (reset) begin
      now_q  <= '0;
      late_q <= '0;
    end else begin
      now_q.valid <= lane_op.valid && !flush;
      if (lane_op.valid) begin
        now_q.data  <= res;
        now_q.flags <= flags;
      end
      late_q <= now_q.data;
    end
  end

  assign result = now_q;
  assign now    = now_q.data;
  assign late   = late_q;

endmodule

// ==== design/issue_latch.sv ====
`timescale 1ns/100ps

module issue_latch (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 flush,
  input  exec_pkg::issue_req_t req,
  input  exec_pkg::data_t      a,
  input  exec_pkg::data_t      b,
  output exec_pkg::lane_op_t   lane_op
);

  import exec_pkg::*;

  lane_ctl_t ctl_next;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // opcode decode
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    ctl_next = '0;
    ctl_next.is_sub = (req.op == op_sub64) || (req.op == op_sub32);
    // logic ops have no 32-bit form
    ctl_next.is_wide = !(req.op inside {op_add32, op_sub32, op_shl32, op_shr32, op_sar32});
    ctl_next.arith = (req.op == op_sar64) || (req.op == op_sar32);
    ctl_next.shift_right = (req.op != op_shl64) && (req.op != op_shl32);
    case (req.op)
      op_and: begin
        ctl_next.logic_sel = sel_and;
      end
      op_or: begin
        ctl_next.logic_sel = sel_or;
      end
      op_xor: begin
        ctl_next.logic_sel = sel_xor;
      end
      default: begin
        ctl_next.logic_sel = sel_arith;
      end
    endcase
  end

  // same-cycle issue is dropped on flush
  always_ff @(posedge clk) begin
    if (reset) begin
      lane_op.valid <= 1'b0;
    end else begin
      lane_op.valid <= req.valid && !flush;
    end
    if (req.valid) begin
      lane_op.ctl <= ctl_next;
      lane_op.a   <= a;
      lane_op.b   <= b;
    end
  end

endmodule

// ==== design/operand_forward.sv ====
`timescale 1ns/100ps

module operand_forward (
  input  exec_pkg::fwd_src_t src,
  input  exec_pkg::data_t    issued,
  input  exec_pkg::data_t    alu_now,
  input  exec_pkg::data_t    shift_now,
  input  exec_pkg::data_t    alu_late,
  input  exec_pkg::data_t    shift_late,
  output exec_pkg::data_t    operand
);

  import exec_pkg::*;

  // five-way pick, result buses taken whatever their valid
  always_comb begin
    case (src)
      src_alu_now: begin
        operand = alu_now;
      end
      src_shift_now: begin
        operand = shift_now;
      end
      src_alu_late: begin
        operand = alu_late;
      end
      src_shift_late: begin
        operand = shift_late;
      end
      default: begin
        operand = issued;
      end
    endcase
  end

endmodule

// ==== design/exec_pkg.sv ====
package exec_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // widths
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int data_width  = 64;
  localparam int half_width  = data_width / 2;
  localparam int shamt_width = $clog2(data_width);
  localparam int op_width    = 8;
  localparam int flag_width  = 4;

  // alu result select
  localparam logic [1:0] sel_arith = 2'd0;
  localparam logic [1:0] sel_and   = 2'd1;
  localparam logic [1:0] sel_or    = 2'd2;
  localparam logic [1:0] sel_xor   = 2'd3;

  typedef logic [data_width-1:0] data_t;

  // zero, sign, carry, overflow from msb down
  typedef logic [flag_width-1:0] flags_t;

  typedef enum logic [op_width-1:0] {
    op_add64 = 8'h01,
    op_add32 = 8'h02,
    op_sub64 = 8'h03,
    op_sub32 = 8'h04,
    op_and   = 8'h05,
    op_or    = 8'h06,
    op_xor   = 8'h07,
    op_shl64 = 8'h10,
    op_shr64 = 8'h11,
    op_sar64 = 8'h12,
    op_shl32 = 8'h13,
    op_shr32 = 8'h14,
    op_sar32 = 8'h15
  } op_t;

  // now = registered result, late = one cycle older
  typedef enum logic [2:0] {
    src_issue      = 3'd0,
    src_alu_now    = 3'd1,
    src_shift_now  = 3'd2,
    src_alu_late   = 3'd3,
    src_shift_late = 3'd4
  } fwd_src_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stage structs
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef struct packed {
    logic     valid;
    op_t      op;
    data_t    a;
    data_t    b;
    fwd_src_t a_src;
    fwd_src_t b_src;
  } issue_req_t;

  typedef struct packed {
    logic       is_sub;
    logic       is_wide;
    logic       arith;
    logic       shift_right;
    logic [1:0] logic_sel;
  } lane_ctl_t;

  typedef struct packed {
    logic      valid;
    lane_ctl_t ctl;
    data_t     a;
    data_t     b;
  } lane_op_t;

  typedef struct packed {
    logic   valid;
    data_t  data;
    flags_t flags;
  } lane_result_t;

endpackage
